/* source/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// load buffer rows
// fill and issue scans adapt to any depth
`define LSU_LB_DEPTH 3

// rob index width, 8 slots
`define LSU_ROB_IX_W 3

// data and byte address width
`define LSU_XLEN 32

// data memory depth in 32-bit words
// index taken from address bits above the byte offset
`define LSU_MEM_WORDS 256

`endif

/* source/lsu_pkg.sv */
`default_nettype none
`include "lsu_defines.svh"

package lsu_pkg;

  // rob slot number
  typedef logic [`LSU_ROB_IX_W-1:0] rob_ix_t;

  // load buffer row number
  typedef logic [$clog2(`LSU_LB_DEPTH)-1:0] lb_row_t;

  // load from address calculation, also the issued request
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    rob_ix_t              rob_ix;
  } load_req_t;

  // committing store, word write
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] data;
    rob_ix_t              rob_ix;
  } store_req_t;

  // completed load back toward the rob
  typedef struct packed {
    logic [`LSU_XLEN-1:0] data;
    rob_ix_t              rob_ix;
  } load_result_t;

endpackage

`default_nettype wire

/* source/load_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_buffer (
  input  wire                      clk_in,
  input  wire                      rst_n,
  input  wire                      flush,
  input  wire                      load_valid,
  input  wire lsu_pkg::load_req_t  load_in,
  input  wire [`LSU_LB_DEPTH-1:0]  row_can_load,
  input  wire                      issue_accept,
  output logic                     load_ready,
  output logic [`LSU_LB_DEPTH-1:0] row_occupied,
  output lsu_pkg::load_req_t       row_entries [`LSU_LB_DEPTH],
  output logic                     issue_valid,
  output lsu_pkg::load_req_t       issue_req
);
  import lsu_pkg::*;

  localparam int DEPTH = `LSU_LB_DEPTH;

  // row payload
  load_req_t        row_q [DEPTH];
  // one occupied bit per row
  logic [DEPTH-1:0] occ_q;
  lb_row_t          fill_row;
  lb_row_t          issue_row;
  // rows that hold a load and passed the ordering check
  logic [DEPTH-1:0] issue_mask;
  logic             fill;
  logic             issue_fire;

  // lowest free row wins
  // scan top down so the last hit is the lowest index
  always_comb begin
    fill_row = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        fill_row = lb_row_t'(i);
      end
    end
  end

  assign issue_mask = occ_q & row_can_load;

  // highest eligible row wins
  always_comb begin
    issue_row = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (issue_mask[i]) begin
        issue_row = lb_row_t'(i);
      end
    end
  end

  // ready straight from occupancy
  // input dropped when full
  assign load_ready   = ~&occ_q;
  assign fill         = load_valid && load_ready;
  // a row filled last edge may go out this cycle
  assign issue_valid  = |issue_mask;
  assign issue_req    = row_q[issue_row];
  assign issue_fire   = issue_valid && issue_accept;
  // rows exported for the age compare
  assign row_occupied = occ_q;
  assign row_entries  = row_q;

  // flush drops every waiting load
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      occ_q <= '0;
    end else if (flush) begin
      occ_q <= '0;
    end else begin
      // fill and issue never hit the same row
      if (issue_fire) begin
        occ_q[issue_row] <= 1'b0;
      end
      if (fill) begin
        occ_q[fill_row] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (fill) begin
      row_q[fill_row] <= load_in;
    end
  end

  // issued row freed at that edge and cannot go out again
  a_issue_frees: assert property (@(posedge clk_in) disable iff (!rst_n)
    issue_fire |=> !occ_q[$past(issue_row)]);

  // taking the last free row with nothing leaving drops ready next cycle
  a_ready_full: assert property (@(posedge clk_in) disable iff (!rst_n)
    fill && !issue_fire && !flush && ($countones(occ_q) == DEPTH - 1)
    |=> !load_ready);

endmodule

`default_nettype wire

/* source/load_order_check.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_order_check (
  input  wire                      clk_in,
  input  wire                      rst_n,
  input  wire                      flush,
  input  wire                      store_alloc,
  input  wire lsu_pkg::rob_ix_t    store_alloc_ix,
  input  wire                      store_commit,
  input  wire lsu_pkg::rob_ix_t    store_commit_ix,
  input  wire lsu_pkg::rob_ix_t    rob_head,
  input  wire [`LSU_LB_DEPTH-1:0]  row_occupied,
  input  wire lsu_pkg::load_req_t  row_entries [`LSU_LB_DEPTH],
  output logic [`LSU_LB_DEPTH-1:0] row_can_load
);
  import lsu_pkg::*;

  localparam int DEPTH     = `LSU_LB_DEPTH;
  localparam int ROB_SLOTS = 1 << `LSU_ROB_IX_W;

  // one bit per rob slot, uncommitted store
  logic [ROB_SLOTS-1:0] pending_q;
  // per row, some older store still waiting
  logic [DEPTH-1:0]     older_pending;

  // distance from the head, wraps with the index width
  function automatic rob_ix_t rob_age(rob_ix_t ix, rob_ix_t head);
    return rob_ix_t'(ix - head);
  endfunction

  // set on alloc, cleared on commit
  // flush wipes all marks, like a mispredict
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else if (flush) begin
      pending_q <= '0;
    end else begin
      if (store_commit) begin
        pending_q[store_commit_ix] <= 1'b0;
      end
      if (store_alloc) begin
        pending_q[store_alloc_ix] <= 1'b1;
      end
    end
  end

  // compare every pending slot against every row
  // strictly smaller age means the store is older than the load
  always_comb begin
    rob_ix_t load_age;
    older_pending = '0;
    for (int r = 0; r < DEPTH; r++) begin
      load_age = rob_age(row_entries[r].rob_ix, rob_head);
      for (int s = 0; s < ROB_SLOTS; s++) begin
        if (pending_q[s] && (rob_age(rob_ix_t'(s), rob_head) < load_age)) begin
          older_pending[r] = 1'b1;
        end
      end
    end
  end

  // empty rows never released
  assign row_can_load = row_occupied & ~older_pending;

  // rob must not hand out a store slot that has not committed yet
  a_alloc_free: assert property (@(posedge clk_in) disable iff (!rst_n)
    store_alloc && !flush |-> !pending_q[store_alloc_ix]);

endmodule

`default_nettype wire

/* source/load_memory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_memory (
  input  wire                      clk_in,
  input  wire                      rst_n,
  input  wire                      issue_valid,
  input  wire lsu_pkg::load_req_t  issue_req,
  input  wire                      store_commit,
  input  wire lsu_pkg::store_req_t store_in,
  input  wire                      result_ready,
  output logic                     issue_accept,
  output logic                     result_valid,
  output lsu_pkg::load_result_t    result_out
);
  import lsu_pkg::*;

  localparam int WORDS = `LSU_MEM_WORDS;
  localparam int IX_W  = $clog2(WORDS);

  // word array
  logic [`LSU_XLEN-1:0] mem [WORDS];
  logic [IX_W-1:0]      rd_ix;
  logic [IX_W-1:0]      wr_ix;
  logic                 issue_fire;
  // single result stage
  logic                 res_valid_q;
  load_result_t         res_q;

  // word index above the byte offset
  assign rd_ix = issue_req.addr[IX_W+1:2];
  assign wr_ix = store_in.addr[IX_W+1:2];

  // take a read when the stage is empty or drains this edge
  assign issue_accept = !res_valid_q || result_ready;
  assign issue_fire   = issue_valid && issue_accept;

  // committed store write port
  always_ff @(posedge clk_in) begin
    if (store_commit) begin
      mem[wr_ix] <= store_in.data;
    end
  end

  // read at the issue edge
  // same edge write to same word still returns the old data
  always_ff @(posedge clk_in) begin
    if (issue_fire) begin
      res_q.data   <= mem[rd_ix];
      res_q.rob_ix <= issue_req.rob_ix;
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else if (issue_fire) begin
      res_valid_q <= 1'b1;
    end else if (result_ready) begin
      res_valid_q <= 1'b0;
    end
  end

  assign result_valid = res_valid_q;
  assign result_out   = res_q;

  // stalled result holds until the consumer takes it
  a_result_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result_out));

endmodule

`default_nettype wire

/* source/load_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_unit_top (
  input  wire                      clk_in,
  input  wire                      rst_n,
  input  wire                      flush,
  input  wire                      load_valid,
  input  wire lsu_pkg::load_req_t  load_in,
  output logic                     load_ready,
  input  wire lsu_pkg::rob_ix_t    rob_head,
  input  wire                      store_alloc,
  input  wire lsu_pkg::rob_ix_t    store_alloc_ix,
  input  wire                      store_commit,
  input  wire lsu_pkg::store_req_t store_in,
  input  wire                      result_ready,
  output logic                     result_valid,
  output lsu_pkg::load_result_t    result_out
);
  import lsu_pkg::*;

  // buffer rows seen by the ordering check
  logic [`LSU_LB_DEPTH-1:0] row_occupied;
  load_req_t                row_entries [`LSU_LB_DEPTH];
  // ordering check verdict per row
  logic [`LSU_LB_DEPTH-1:0] row_can_load;
  // buffer to memory
  logic                     issue_valid;
  load_req_t                issue_req;
  logic                     issue_accept;

  load_buffer i_load_buffer (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .flush        (flush),
    .load_valid   (load_valid),
    .load_in      (load_in),
    .row_can_load (row_can_load),
    .issue_accept (issue_accept),
    .load_ready   (load_ready),
    .row_occupied (row_occupied),
    .row_entries  (row_entries),
    .issue_valid  (issue_valid),
    .issue_req    (issue_req)
  );

  // commit slot comes with the store itself
  load_order_check i_load_order_check (
    .clk_in          (clk_in),
    .rst_n           (rst_n),
    .flush           (flush),
    .store_alloc     (store_alloc),
    .store_alloc_ix  (store_alloc_ix),
    .store_commit    (store_commit),
    .store_commit_ix (store_in.rob_ix),
    .rob_head        (rob_head),
    .row_occupied    (row_occupied),
    .row_entries     (row_entries),
    .row_can_load    (row_can_load)
  );

  load_memory i_load_memory (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_req    (issue_req),
    .store_commit (store_commit),
    .store_in     (store_in),
    .result_ready (result_ready),
    .issue_accept (issue_accept),
    .result_valid (result_valid),
    .result_out   (result_out)
  );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_in
);
  // free running, starts low
  initial begin
    clk_in = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_in = ~clk_in;
    end
  end
endmodule

`default_nettype wire

/* verification/load_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_unit_tb;
  import lsu_pkg::*;

  localparam int SLOTS    = 1 << `LSU_ROB_IX_W;
  localparam int MEM_IX_W = $clog2(`LSU_MEM_WORDS);

  logic         clk_in;
  logic         rst_n          = 1'b0;
  logic         flush          = 1'b0;
  logic         load_valid     = 1'b0;
  load_req_t    load_in        = '0;
  logic         load_ready;
  rob_ix_t      rob_head       = '0;
  logic         store_alloc    = 1'b0;
  rob_ix_t      store_alloc_ix = '0;
  logic         store_commit   = 1'b0;
  store_req_t   store_in       = '0;
  logic         result_ready   = 1'b1;
  logic         result_valid;
  load_result_t result_out;

  // reference words behind the committed stores
  logic [`LSU_XLEN-1:0] ref_mem [`LSU_MEM_WORDS];
  // scoreboard per rob slot
  logic [`LSU_XLEN-1:0] exp_addr [SLOTS];
  logic [SLOTS-1:0]     expect_ret = '0;
  // loads waiting behind an older store
  logic [SLOTS-1:0]     held       = '0;
  // uncommitted store slots
  logic [SLOTS-1:0]     pend       = '0;
  logic [31:0]          lcg_state  = 32'hd5302a39;
  int                   errors     = 0;
  int                   err_mark   = 0;
  int                   tests_run  = 0;
  string                test_name  = "reset";

  tb_clock i_clock (.clk_in(clk_in));

  // port names match the local signals
  load_unit_top i_dut (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // a store is older when it sits closer to the head
  function automatic logic older_store_pending(rob_ix_t ix);
    logic hit;
    hit = 1'b0;
    for (int s = 0; s < SLOTS; s++) begin
      hit |= pend[s] && (rob_ix_t'(rob_ix_t'(s) - rob_head) < rob_ix_t'(ix - rob_head));
    end
    return hit;
  endfunction

  // consumed word equals the reference word at the load address
  a_data: assert property (@(posedge clk_in) disable iff (!rst_n)
    result_valid && result_ready
    |-> result_out.data == ref_mem[exp_addr[result_out.rob_ix][MEM_IX_W+1:2]])
    else begin
      $display("Error %s: data expected %h actual %h", test_name,
               ref_mem[exp_addr[$sampled(result_out.rob_ix)][MEM_IX_W+1:2]],
               $sampled(result_out.data));
      errors++;
    end

  // held, dropped, flushed or repeated loads never show up
  a_expected: assert property (@(posedge clk_in) disable iff (!rst_n)
    result_valid |-> expect_ret[result_out.rob_ix])
    else begin
      $display("Error %s: rob slot %0d returned a result that was not due", test_name,
               $sampled(result_out.rob_ix));
      errors++;
    end

  // stalled result holds still
  a_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result_out))
    else begin
      $display("Error %s: result changed or vanished while stalled", test_name);
      errors++;
    end

  a_flush_ready: assert property (@(posedge clk_in) disable iff (!rst_n)
    flush |=> load_ready)
    else begin
      $display("Error %s: load_ready expected 1 actual 0 after flush", test_name);
      errors++;
    end

  // consumed results leave the scoreboard
  always @(posedge clk_in) begin
    if (rst_n && result_valid && result_ready) begin
      expect_ret[result_out.rob_ix] = 1'b0;
    end
  end

  // bounded wait until every due result is consumed
  task automatic wait_drain();
    int n;
    n = 0;
    while (expect_ret != '0 && n < 100) begin
      @(negedge clk_in);
      n++;
    end
    if (expect_ret != '0) begin
      $display("timeout in %s: no result yet for rob slots %b", test_name, expect_ret);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  // a load offered while full is dropped and never due
  task automatic enqueue(input rob_ix_t ix, input logic [31:0] ld_addr);
    load_valid     = 1'b1;
    load_in        = '{addr: ld_addr, rob_ix: ix};
    exp_addr[ix]   = ld_addr;
    held[ix]       = load_ready && older_store_pending(ix);
    expect_ret[ix] = load_ready && !held[ix];
    @(negedge clk_in);
    load_valid = 1'b0;
  endtask

  task automatic alloc_store(input rob_ix_t ix);
    store_alloc    = 1'b1;
    store_alloc_ix = ix;
    pend[ix]       = 1'b1;
    @(negedge clk_in);
    store_alloc = 1'b0;
  endtask

  // loads with no older store left become due
  task automatic commit_store(input rob_ix_t ix, input logic [31:0] st_addr,
                              input logic [31:0] st_data);
    store_commit = 1'b1;
    store_in     = '{addr: st_addr, data: st_data, rob_ix: ix};
    ref_mem[st_addr[MEM_IX_W+1:2]] = st_data;
    pend[ix] = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      if (held[i] && !older_store_pending(rob_ix_t'(i))) begin
        held[i]       = 1'b0;
        expect_ret[i] = 1'b1;
      end
    end
    @(negedge clk_in);
    store_commit = 1'b0;
  endtask

  task automatic end_test();
    $display("test %s: %s", test_name, (errors == err_mark) ? "ok" : "failed");
    tests_run++;
    err_mark = errors;
  endtask

  initial begin
    logic [31:0] addrs [SLOTS];
    logic [1:0]  seen;
    repeat (5) @(negedge clk_in);
    rst_n = 1'b1;

    // random stores, then one load per slot from the same words
    test_name = "data";
    for (int k = 0; k < SLOTS; k++) begin
      addrs[k] = lcg_next() & ~32'h3;
      commit_store(rob_ix_t'(k), addrs[k], lcg_next());
    end
    for (int k = 0; k < SLOTS; k++) begin
      enqueue(rob_ix_t'(k), addrs[k]);
      wait_drain();
    end
    end_test();

    // head at 6, store in slot 0, load 2 behind it, load 7 ahead of it
    test_name = "order";
    rob_head = 3'd6;
    alloc_store(3'd0);
    enqueue(3'd2, addrs[2]);
    enqueue(3'd7, addrs[7]);
    wait_drain();
    repeat (4) @(negedge clk_in);
    commit_store(3'd0, addrs[2], lcg_next());
    wait_drain();
    end_test();

    // result stage blocked, one load in it and the rows filling up
    test_name = "full";
    result_ready = 1'b0;
    for (int k = 0; k <= `LSU_LB_DEPTH; k++) begin
      enqueue(rob_ix_t'(k), addrs[k]);
    end
    assert (!load_ready) else begin
      $display("Error %s: load_ready expected 0 actual 1", test_name);
      errors++;
    end
    enqueue(3'd7, addrs[7]);
    result_ready = 1'b1;
    wait_drain();
    repeat (4) @(negedge clk_in);
    end_test();

    // stall, then drain
    test_name = "backpressure";
    result_ready = 1'b0;
    for (int k = 4; k < 7; k++) begin
      enqueue(rob_ix_t'(k), addrs[k]);
    end
    repeat (6) @(negedge clk_in);
    result_ready = 1'b1;
    wait_drain();
    end_test();

    // store in slot 7 holds younger loads 0 to 2 until the flush drops them
    test_name = "flush";
    alloc_store(3'd7);
    for (int k = 0; k < `LSU_LB_DEPTH; k++) begin
      enqueue(rob_ix_t'(k), addrs[k]);
    end
    flush = 1'b1;
    held  = '0;
    pend  = '0;
    @(negedge clk_in);
    flush = 1'b0;
    repeat (6) @(negedge clk_in);
    end_test();

    // empty buffer, nothing pending, result after the second edge
    test_name = "latency";
    enqueue(3'd3, addrs[3]);
    seen[1] = result_valid;
    @(negedge clk_in);
    seen[0] = result_valid;
    assert (seen == 2'b01) else begin
      $display("Error %s: result_valid after edges 1 and 2 expected 01 actual %b",
               test_name, seen);
      errors++;
    end
    wait_drain();
    end_test();

    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/lsu_pkg.sv
source/load_buffer.sv
source/load_order_check.sv
source/load_memory.sv
source/load_unit_top.sv
verification/tb_clock.sv
verification/load_unit_tb.sv

/* Bender.yml */
package:
  name: load_unit

export_include_dirs:
  - source

sources:
  - source/lsu_pkg.sv
  - source/load_buffer.sv
  - source/load_order_check.sv
  - source/load_memory.sv
  - source/load_unit_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/load_unit_tb.sv
